// File: verilog/maskPkg.sv
`default_nettype none

package maskPkg;

    // operations understood by the engine
    typedef enum logic [2:0] {
        MONO_UP      = 3'd0,
        MONO_DOWN    = 3'd1,
        ISOLATE_LOW  = 3'd2,
        ISOLATE_HIGH = 3'd3,
        SPAN         = 3'd4
    } maskOp;

    // default vector width, modules take it as their WIDTH default
    localparam int MASK_WIDTH = 128;

    // holds 0 to MASK_WIDTH inclusive
    localparam int INDEX_WIDTH = $clog2(MASK_WIDTH) + 1;

    // request strobe to response strobe, in cycles
    localparam int ENGINE_LATENCY = 4;

    typedef struct packed {
        maskOp                 op;
        logic [MASK_WIDTH-1:0] vector;
    } maskReq;

    typedef struct packed {
        maskOp                  op;
        logic [MASK_WIDTH-1:0]  mask;
        logic [INDEX_WIDTH-1:0] index;
        logic                   empty;
    } maskResp;

endpackage

`default_nettype wire

// File: verilog/monotonizeUp.sv
`timescale 1ns/1ps
`default_nettype none

module monotonizeUp
    import maskPkg::*;
#(
    parameter int WIDTH = MASK_WIDTH
) (
    input  wire              clk,
    input  wire [WIDTH-1:0]  vIn,
    output logic [WIDTH-1:0] vOut
);

    localparam int LEVELS = $clog2(WIDTH);
    // register points split the OR levels roughly in thirds
    localparam int REG_A = (LEVELS - 1) / 3;
    localparam int REG_B = 2 * (LEVELS - 1) / 3 + 1;

    wire [WIDTH-1:0] level [0:LEVELS];

    assign level[0] = vIn;

    for (genvar l = 0; l < LEVELS; l++) begin : gLevel
        localparam int STEP = 1 << l;
        wire [WIDTH-1:0] orNext;

        for (genvar i = 0; i < WIDTH; i++) begin : gBit
            localparam int BASE = i - (i % (2 * STEP));
            if (i - BASE >= STEP) begin : gOr
                // top bit of the lower half already covers that half
                assign orNext[i] = level[l][i] | level[l][BASE + STEP - 1];
            end else begin : gKeep
                assign orNext[i] = level[l][i];
            end
        end

        if (l == REG_A || l == REG_B) begin : gReg
            logic [WIDTH-1:0] stageQ;
            always_ff @(posedge clk) begin
                stageQ <= orNext;
            end
            assign level[l + 1] = stageQ;
        end else begin : gComb
            assign level[l + 1] = orNext;
        end
    end

    assign vOut = level[LEVELS];

endmodule

`default_nettype wire

// File: verilog/monotonizeDown.sv
`timescale 1ns/1ps
`default_nettype none

module monotonizeDown
    import maskPkg::*;
#(
    parameter int WIDTH = MASK_WIDTH
) (
    input  wire              clk,
    input  wire [WIDTH-1:0]  vIn,
    output logic [WIDTH-1:0] vOut
);

    localparam int LEVELS = $clog2(WIDTH);
    // same register points as the upward network
    localparam int REG_A = (LEVELS - 1) / 3;
    localparam int REG_B = 2 * (LEVELS - 1) / 3 + 1;

    wire [WIDTH-1:0] level [0:LEVELS];

    assign level[0] = vIn;

    for (genvar l = 0; l < LEVELS; l++) begin : gLevel
        localparam int STEP = 1 << l;
        wire [WIDTH-1:0] orNext;

        for (genvar i = 0; i < WIDTH; i++) begin : gBit
            localparam int BASE = i - (i % (2 * STEP));
            if ((i - BASE < STEP) && (BASE + STEP < WIDTH)) begin : gOr
                // first bit of the upper half carries the whole half
                assign orNext[i] = level[l][i] | level[l][BASE + STEP];
            end else begin : gKeep
                assign orNext[i] = level[l][i];
            end
        end

        if (l == REG_A || l == REG_B) begin : gReg
            logic [WIDTH-1:0] stageQ;
            always_ff @(posedge clk) begin
                stageQ <= orNext;
            end
            assign level[l + 1] = stageQ;
        end else begin : gComb
            assign level[l + 1] = orNext;
        end
    end

    assign vOut = level[LEVELS];

endmodule

`default_nettype wire

// File: verilog/maskCombine.sv
`timescale 1ns/1ps
`default_nettype none

module maskCombine
    import maskPkg::*;
#(
    parameter int WIDTH = MASK_WIDTH
) (
    input  wire              clk,
    input  wire maskOp       op,
    input  wire [WIDTH-1:0]  upMask,
    input  wire [WIDTH-1:0]  downMask,
    output logic [WIDTH-1:0] mask,
    output logic [WIDTH-1:0] countSource,
    output logic             empty
);

    logic [WIDTH-1:0] nextMask;
    logic [WIDTH-1:0] nextCount;

    always_comb begin
        case (op)
            MONO_UP:      nextMask = upMask;
            MONO_DOWN:    nextMask = downMask;
            // edge of the monotone mask is the isolated bit
            ISOLATE_LOW:  nextMask = upMask & ~(upMask << 1);
            ISOLATE_HIGH: nextMask = downMask & ~(downMask >> 1);
            SPAN:         nextMask = upMask & downMask;
            default:      nextMask = '0;
        endcase
    end

    // isolate opcodes derive the position from the monotone mask
    always_comb begin
        case (op)
            ISOLATE_LOW:  nextCount = upMask;
            ISOLATE_HIGH: nextCount = downMask;
            default:      nextCount = nextMask;
        endcase
    end

    always_ff @(posedge clk) begin
        mask        <= nextMask;
        countSource <= nextCount;
        // bit 0 of the down mask is the OR of every input bit
        empty       <= ~downMask[0];
    end

    // both networks see the same vector, so the full-OR bits must match
    emptyAgree: assert property (@(posedge clk)
        !$isunknown({upMask[WIDTH-1], downMask[0]}) |->
            (upMask[WIDTH-1] == downMask[0]));

endmodule

`default_nettype wire

// File: verilog/indexUnit.sv
`timescale 1ns/1ps
`default_nettype none

module indexUnit
    import maskPkg::*;
#(
    parameter int WIDTH = MASK_WIDTH
) (
    input  wire                    clk,
    input  wire maskOp             op,
    input  wire [WIDTH-1:0]        maskIn,
    input  wire [WIDTH-1:0]        countSource,
    input  wire                    emptyIn,
    output logic [WIDTH-1:0]       mask,
    output logic [INDEX_WIDTH-1:0] index,
    output logic                   empty
);

    // tree padded up to a power of two
    localparam int LEAVES = 1 << $clog2(WIDTH);

    // heap order, node n sums nodes 2n+1 and 2n+2
    wire [INDEX_WIDTH-1:0] node [0:2*LEAVES-2];
    wire [INDEX_WIDTH-1:0] count;
    logic [INDEX_WIDTH-1:0] rawIndex;

    for (genvar n = 0; n < LEAVES; n++) begin : gLeaf
        if (n < WIDTH) begin : gBit
            assign node[LEAVES - 1 + n] = INDEX_WIDTH'(countSource[n]);
        end else begin : gPad
            assign node[LEAVES - 1 + n] = '0;
        end
    end

    for (genvar n = 0; n < LEAVES - 1; n++) begin : gSum
        assign node[n] = node[2 * n + 1] + node[2 * n + 2];
    end

    assign count = node[0];

    always_comb begin
        case (op)
            // up mask holds WIDTH - pos ones
            ISOLATE_LOW:  rawIndex = INDEX_WIDTH'(WIDTH) - count;
            // down mask holds pos + 1 ones
            ISOLATE_HIGH: rawIndex = count - INDEX_WIDTH'(1);
            default:      rawIndex = count;
        endcase
    end

    always_ff @(posedge clk) begin
        mask  <= maskIn;
        index <= emptyIn ? '0 : rawIndex;
        empty <= emptyIn;
    end

    // a bad count source or opcode alignment upstream would overflow here
    isolateRange: assert property (@(posedge clk)
        (op inside {ISOLATE_LOW, ISOLATE_HIGH}) && (emptyIn == 1'b0) |=>
            (index < INDEX_WIDTH'(WIDTH)));

endmodule

`default_nettype wire

// File: verilog/maskControl.sv
`timescale 1ns/1ps
`default_nettype none

module maskControl
    import maskPkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        reqValid,
    input  wire maskOp reqOp,
    output maskOp      combineOp,
    output maskOp      indexOp,
    output maskOp      respOp,
    output logic       respValid,
    output logic [2:0] inFlight
);

    typedef struct packed {
        logic  valid;
        maskOp op;
    } stageEntry;

    // stage k holds the request accepted k cycles ago
    stageEntry [ENGINE_LATENCY:1] stage;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
        end else begin
            stage <= {stage[ENGINE_LATENCY-1:1], stageEntry'{valid: reqValid, op: reqOp}};
        end
    end

    assign combineOp = stage[2].op;
    assign indexOp   = stage[ENGINE_LATENCY-1].op;
    assign respOp    = stage[ENGINE_LATENCY].op;
    assign respValid = stage[ENGINE_LATENCY].valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            inFlight <= '0;
        end else if (reqValid && !respValid) begin
            inFlight <= inFlight + 3'd1;
        end else if (!reqValid && respValid) begin
            inFlight <= inFlight - 3'd1;
        end
    end

    respAfterReq: assert property (@(posedge clk) disable iff (reset)
        reqValid |-> ##ENGINE_LATENCY respValid);

    reqBeforeResp: assert property (@(posedge clk) disable iff (reset)
        respValid |-> $past(reqValid, ENGINE_LATENCY));

    inFlightBound: assert property (@(posedge clk) disable iff (reset)
        inFlight <= 3'(ENGINE_LATENCY));

    legalOp: assert property (@(posedge clk) disable iff (reset)
        reqValid |-> reqOp inside {MONO_UP, MONO_DOWN, ISOLATE_LOW, ISOLATE_HIGH, SPAN});

endmodule

`default_nettype wire

// File: verilog/maskEngine.sv
`timescale 1ns/1ps
`default_nettype none

module maskEngine
    import maskPkg::*;
#(
    parameter int WIDTH = MASK_WIDTH
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         reqValid,
    input  wire maskReq req,
    output logic        respValid,
    output maskResp     resp,
    output logic [2:0]  inFlight
);

    // opcode taps of the delay line
    maskOp combineOp;
    maskOp indexOp;
    maskOp respOp;

    // monotone masks, valid two cycles after the request
    wire [WIDTH-1:0] upMask;
    wire [WIDTH-1:0] downMask;

    // combine stage outputs
    wire [WIDTH-1:0] combMask;
    wire [WIDTH-1:0] countSource;
    wire             combEmpty;

    // index stage outputs
    wire [WIDTH-1:0]       respMask;
    wire [INDEX_WIDTH-1:0] respIndex;
    wire                   respEmpty;

    maskControl i_maskControl (
        .clk       (clk),
        .reset     (reset),
        .reqValid  (reqValid),
        .reqOp     (req.op),
        .combineOp (combineOp),
        .indexOp   (indexOp),
        .respOp    (respOp),
        .respValid (respValid),
        .inFlight  (inFlight)
    );

    monotonizeUp #(
        .WIDTH (WIDTH)
    ) i_monotonizeUp (
        .clk  (clk),
        .vIn  (req.vector),
        .vOut (upMask)
    );

    monotonizeDown #(
        .WIDTH (WIDTH)
    ) i_monotonizeDown (
        .clk  (clk),
        .vIn  (req.vector),
        .vOut (downMask)
    );

    maskCombine #(
        .WIDTH (WIDTH)
    ) i_maskCombine (
        .clk         (clk),
        .op          (combineOp),
        .upMask      (upMask),
        .downMask    (downMask),
        .mask        (combMask),
        .countSource (countSource),
        .empty       (combEmpty)
    );

    indexUnit #(
        .WIDTH (WIDTH)
    ) i_indexUnit (
        .clk         (clk),
        .op          (indexOp),
        .maskIn      (combMask),
        .countSource (countSource),
        .emptyIn     (combEmpty),
        .mask        (respMask),
        .index       (respIndex),
        .empty       (respEmpty)
    );

    assign resp = '{op: respOp, mask: respMask, index: respIndex, empty: respEmpty};

endmodule

`default_nettype wire

// File: tb/maskEngineTb.sv
`timescale 1ns/1ps
`default_nettype none

module maskEngineTb
    import maskPkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RESP_LATENCY = 4;
    localparam int MAX_VECTORS = 64;
    localparam int NAME_BITS = 8 * 24;

    // one line of the vector file
    typedef struct packed {
        logic [NAME_BITS-1:0]   name;
        logic [2:0]             op;
        logic [MASK_WIDTH-1:0]  vector;
        logic [MASK_WIDTH-1:0]  mask;
        logic [INDEX_WIDTH-1:0] index;
        logic                   empty;
    } vectorEntry;

    typedef struct packed {
        vectorEntry vec;
        int         issue;
    } pendingEntry;

    logic       clk;
    logic       reset;
    logic       reqValid;
    maskReq     req;
    logic       respValid;
    maskResp    resp;
    logic [2:0] inFlight;

    vectorEntry  vectors [0:MAX_VECTORS-1];
    pendingEntry expectQ [$];
    int          vectorCount = 0;
    int          errorCount = 0;
    int          cycleCount = 0;
    int          timeoutLimit = 0;
    integer      seed;

    maskEngine #(
        .WIDTH (MASK_WIDTH)
    ) i_maskEngine (
        .clk       (clk),
        .reset     (reset),
        .reqValid  (reqValid),
        .req       (req),
        .respValid (respValid),
        .resp      (resp),
        .inFlight  (inFlight)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // armed once the number of vectors is known
    always @(posedge clk) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("timeout: responses still outstanding after %0d cycles", cycleCount);
            $display("errors: %0d, vectors: %0d", errorCount + 1, vectorCount);
            $display("test failed");
            $finish;
        end
    end

    task automatic reportMismatch(input logic [NAME_BITS-1:0] name, input string field,
                                  input logic [MASK_WIDTH-1:0] expected,
                                  input logic [MASK_WIDTH-1:0] actual);
        $display("[ERROR] %0s %0s: expected %0h actual %0h", name, field, expected, actual);
        errorCount++;
    endtask

    task automatic loadVectors();
        int fd;
        int code;
        int ch;
        logic [NAME_BITS-1:0]   nameTok;
        logic [2:0]             opVal;
        logic [MASK_WIDTH-1:0]  vecVal;
        logic [MASK_WIDTH-1:0]  maskVal;
        logic [INDEX_WIDTH-1:0] indexVal;
        logic                   emptyVal;
        fd = $fopen("tb/maskVectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file tb/maskVectors.txt");
            errorCount++;
            return;
        end
        while ($feof(fd) == 0 && vectorCount < MAX_VECTORS) begin
            code = $fscanf(fd, "%s", nameTok);
            if (code != 1) begin
                break;
            end
            if (nameTok == NAME_BITS'("#")) begin
                // comment, skip to end of line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h", opVal, vecVal, maskVal, indexVal, emptyVal);
                if (code != 5) begin
                    $display("vector file entry %0s is malformed", nameTok);
                    errorCount++;
                    break;
                end
                vectors[vectorCount] = '{nameTok, opVal, vecVal, maskVal, indexVal, emptyVal};
                vectorCount++;
            end
        end
        $fclose(fd);
    endtask

    // outputs are settled at the falling edge
    task automatic checkResponse();
        pendingEntry exp;
        if (inFlight != 3'(expectQ.size())) begin
            reportMismatch(NAME_BITS'("inFlight"), "count", MASK_WIDTH'(expectQ.size()),
                           MASK_WIDTH'(inFlight));
        end
        if (respValid) begin
            if (expectQ.size() == 0) begin
                $display("response strobe at cycle %0d with no request outstanding", cycleCount);
                errorCount++;
            end else begin
                exp = expectQ.pop_front();
                if (cycleCount - exp.issue != RESP_LATENCY) begin
                    reportMismatch(exp.vec.name, "latency", MASK_WIDTH'(RESP_LATENCY),
                                   MASK_WIDTH'(cycleCount - exp.issue));
                end
                if (resp.op != exp.vec.op) begin
                    reportMismatch(exp.vec.name, "op", MASK_WIDTH'(exp.vec.op),
                                   MASK_WIDTH'(resp.op));
                end
                if (resp.mask != exp.vec.mask) begin
                    reportMismatch(exp.vec.name, "mask", exp.vec.mask, resp.mask);
                end
                if (resp.index != exp.vec.index) begin
                    reportMismatch(exp.vec.name, "index", MASK_WIDTH'(exp.vec.index),
                                   MASK_WIDTH'(resp.index));
                end
                if (resp.empty != exp.vec.empty) begin
                    reportMismatch(exp.vec.name, "empty", MASK_WIDTH'(exp.vec.empty),
                                   MASK_WIDTH'(resp.empty));
                end
            end
        end else if (expectQ.size() > 0 && cycleCount - expectQ[0].issue >= RESP_LATENCY) begin
            exp = expectQ.pop_front();
            $display("no response for %0s requested at cycle %0d", exp.vec.name, exp.issue);
            errorCount++;
        end
    endtask

    task automatic driveCycle(input logic valid, input vectorEntry entry);
        @(negedge clk);
        checkResponse();
        reqValid = valid;
        if (valid) begin
            req.op = maskOp'(entry.op);
            req.vector = entry.vector;
            expectQ.push_back('{vec: entry, issue: cycleCount});
        end
    endtask

    initial begin
        int gap;
        reset = 1'b1;
        reqValid = 1'b0;
        req = '0;
        seed = 32'ha083;
        loadVectors();
        if (vectorCount == 0) begin
            $display("no vectors were read");
            errorCount++;
        end
        timeoutLimit = 4 * vectorCount + 50;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (respValid !== 1'b0 || inFlight !== 3'd0) begin
            $display("respValid or inFlight not clear after reset");
            errorCount++;
        end
        for (int i = 0; i < vectorCount; i++) begin
            // occasional idle gap, otherwise back to back
            if (($random(seed) & 7) == 0) begin
                gap = 1 + ($random(seed) & 1);
                repeat (gap) driveCycle(1'b0, '0);
            end
            driveCycle(1'b1, vectors[i]);
        end
        driveCycle(1'b0, '0);
        while (expectQ.size() > 0) begin
            driveCycle(1'b0, '0);
        end
        // counter drops on the edge after the last strobe
        driveCycle(1'b0, '0);
        if (inFlight != 3'd0) begin
            reportMismatch(NAME_BITS'("drain"), "inFlight", '0, MASK_WIDTH'(inFlight));
        end
        $display("errors: %0d, vectors: %0d", errorCount, vectorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/maskVectors.txt
# name op vector expectedMask expectedIndex expectedEmpty, all but the name in hex
# op codes are 0 MONO_UP, 1 MONO_DOWN, 2 ISOLATE_LOW, 3 ISOLATE_HIGH, 4 SPAN
upBit0      0 00000000000000000000000000000001 ffffffffffffffffffffffffffffffff 80 0
upBit127    0 80000000000000000000000000000000 80000000000000000000000000000000 01 0
upSparse    0 00000000000100000000000000000100 ffffffffffffffffffffffffffffff00 78 0
upFull      0 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff 80 0
upZero      0 00000000000000000000000000000000 00000000000000000000000000000000 00 1
downBit0    1 00000000000000000000000000000001 00000000000000000000000000000001 01 0
downBit127  1 80000000000000000000000000000000 ffffffffffffffffffffffffffffffff 80 0
downSparse  1 00000000000100000000000000000100 000000000001ffffffffffffffffffff 51 0
downFull    1 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff 80 0
downZero    1 00000000000000000000000000000000 00000000000000000000000000000000 00 1
lowBit0     2 00000000000000000000000000000001 00000000000000000000000000000001 00 0
lowBit127   2 80000000000000000000000000000000 80000000000000000000000000000000 7f 0
lowSparse   2 00000000000100000000000000000100 00000000000000000000000000000100 08 0
lowFull     2 ffffffffffffffffffffffffffffffff 00000000000000000000000000000001 00 0
lowMid      2 f0000000000000000000003000000000 00000000000000000000001000000000 24 0
lowZero     2 00000000000000000000000000000000 00000000000000000000000000000000 00 1
highBit0    3 00000000000000000000000000000001 00000000000000000000000000000001 00 0
highBit127  3 80000000000000000000000000000000 80000000000000000000000000000000 7f 0
highSparse  3 00000000000100000000000000000100 00000000000100000000000000000000 50 0
highFull    3 ffffffffffffffffffffffffffffffff 80000000000000000000000000000000 7f 0
highMid     3 0000000000000300000000000000000f 00000000000002000000000000000000 49 0
highZero    3 00000000000000000000000000000000 00000000000000000000000000000000 00 1
spanBit0    4 00000000000000000000000000000001 00000000000000000000000000000001 01 0
spanEnds    4 80000000000000000000000000000001 ffffffffffffffffffffffffffffffff 80 0
spanSparse  4 00000000000100000000000000000100 000000000001ffffffffffffffffff00 49 0
spanMid     4 0000000000000300000000000000000f 00000000000003ffffffffffffffffff 4a 0
spanOne     4 00000000000000010000000000000000 00000000000000010000000000000000 01 0
spanZero    4 00000000000000000000000000000000 00000000000000000000000000000000 00 1

// File: verilog.f
verilog/maskPkg.sv
verilog/monotonizeUp.sv
verilog/monotonizeDown.sv
verilog/maskCombine.sv
verilog/indexUnit.sv
verilog/maskControl.sv
verilog/maskEngine.sv
tb/maskEngineTb.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP        = maskEngineTb
RTL_TOP    = maskEngine
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
